//--- logic/mem_stage_pkg.sv
package mem_stage_pkg;

    // datapath widths
    // the load extension logic is written for a 32-bit word
    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int FUNCT3_W   = 3;
    localparam int BE_W       = DATA_W / 8;

    // one-hot opcode class vector, one bit per class
    localparam int OPCODE_W  = 8;
    localparam int OP_LOAD   = 0;
    localparam int OP_STORE  = 1;
    localparam int OP_RTYPE  = 2;
    localparam int OP_ITYPE  = 3;
    localparam int OP_JAL    = 4;
    localparam int OP_JALR   = 5;
    localparam int OP_LUI    = 6;
    localparam int OP_AUIPC  = 7;

    // funct3 access size codes, shared by loads and stores
    localparam logic [FUNCT3_W-1:0] F3_B  = 3'd0;
    localparam logic [FUNCT3_W-1:0] F3_H  = 3'd1;
    localparam logic [FUNCT3_W-1:0] F3_W  = 3'd2;
    localparam logic [FUNCT3_W-1:0] F3_BU = 3'd4;
    localparam logic [FUNCT3_W-1:0] F3_HU = 3'd5;

    // instruction as handed over by the execute stage
    typedef struct packed {
        logic [OPCODE_W-1:0]   opcode;
        logic [FUNCT3_W-1:0]   funct3;
        logic [REG_ADDR_W-1:0] rd_addr;
        // register write requested by decode
        logic                  we_reg;
        // effective address for memory ops, ALU result otherwise
        logic [DATA_W-1:0]     alu_value;
        // store data
        logic [DATA_W-1:0]     rs2_data;
        // result for non-memory ops
        logic [DATA_W-1:0]     rd_data;
    } ex_mem_t;

    // record handed to write-back
    typedef struct packed {
        logic [OPCODE_W-1:0]   opcode;
        logic [FUNCT3_W-1:0]   funct3;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  rd_we;
        logic [DATA_W-1:0]     rd_data;
    } mem_wb_t;

endpackage

//--- logic/store_align.sv
`timescale 1ns/1ps

module store_align (
    input  logic [mem_stage_pkg::FUNCT3_W-1:0] funct3,
    input  logic [1:0]                         offset,
    input  logic [mem_stage_pkg::DATA_W-1:0]   rs2_data,
    output logic [mem_stage_pkg::DATA_W-1:0]   wdata,
    output logic [mem_stage_pkg::BE_W-1:0]     be
);
    import mem_stage_pkg::*;

    // byte offset as a bit shift
    logic [4:0] bit_shift;

    assign bit_shift = {offset, 3'b000};

    always_comb begin
        wdata = '0;
        be    = '0;
        case (funct3)
            F3_B: begin
                // byte copied into every lane, one lane enabled
                wdata = {4{rs2_data[7:0]}} << bit_shift;
                be    = 4'b0001 << offset;
            end
            F3_H: begin
                // halfword crossing the word edge is not split
                if (offset != 2'd3) begin
                    wdata = {2{rs2_data[15:0]}} << bit_shift;
                    be    = 4'b0011 << offset;
                end
            end
            F3_W: begin
                // full word, low address bits ignored
                wdata = rs2_data;
                be    = 4'b1111;
            end
            default: begin
                wdata = '0;
                be    = '0;
            end
        endcase
    end

endmodule

//--- logic/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int MEM_ADDR_W  = 5,
    parameter int RAM_LATENCY = 2
) (
    input  logic                             me_clk,
    input  logic                             me_rst,
    input  logic                             req,
    input  logic                             we,
    input  logic [MEM_ADDR_W-1:0]            addr,
    input  logic [mem_stage_pkg::BE_W-1:0]   be,
    input  logic [mem_stage_pkg::DATA_W-1:0] wdata,
    output logic                             ack,
    output logic [mem_stage_pkg::DATA_W-1:0] rdata
);
    import mem_stage_pkg::*;

    localparam int DEPTH = 1 << MEM_ADDR_W;

    logic [DATA_W-1:0]      mem [DEPTH];
    logic [RAM_LATENCY-1:0] ack_sr;
    logic [DATA_W-1:0]      rd_pipe [RAM_LATENCY];

    // storage array, zeroed at reset
    always_ff @(posedge me_clk or negedge me_rst) begin
        if (!me_rst) begin
            for (int w = 0; w < DEPTH; w++) begin
                mem[w] <= '0;
            end
        end else if (req && we) begin
            // byte lanes written independently
            for (int b = 0; b < BE_W; b++) begin
                if (be[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // fixed latency ack, one stage per cycle
    always_ff @(posedge me_clk or negedge me_rst) begin
        if (!me_rst) begin
            ack_sr <= '0;
        end else begin
            ack_sr[0] <= req;
            for (int i = 1; i < RAM_LATENCY; i++) begin
                ack_sr[i] <= ack_sr[i-1];
            end
        end
    end

    // read word follows the same delay as ack
    always_ff @(posedge me_clk) begin
        if (req && !we) begin
            rd_pipe[0] <= mem[addr];
        end
        for (int i = 1; i < RAM_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign ack   = ack_sr[RAM_LATENCY-1];
    assign rdata = rd_pipe[RAM_LATENCY-1];

endmodule

//--- logic/load_extend.sv
`timescale 1ns/1ps

module load_extend (
    input  logic [mem_stage_pkg::FUNCT3_W-1:0] funct3,
    input  logic [1:0]                         offset,
    input  logic [mem_stage_pkg::DATA_W-1:0]   rdata,
    output logic [mem_stage_pkg::DATA_W-1:0]   value
);
    import mem_stage_pkg::*;

    // addressed byte moved down to lane 0
    logic [DATA_W-1:0] raw;

    assign raw = rdata >> {offset, 3'b000};

    always_comb begin
        case (funct3)
            F3_B: begin
                value = {{(DATA_W-8){raw[7]}}, raw[7:0]};
            end
            F3_BU: begin
                value = {{(DATA_W-8){1'b0}}, raw[7:0]};
            end
            F3_H: begin
                value = {{(DATA_W-16){raw[15]}}, raw[15:0]};
            end
            F3_HU: begin
                value = {{(DATA_W-16){1'b0}}, raw[15:0]};
            end
            F3_W: begin
                // upper lanes already zero filled for unaligned words
                value = raw;
            end
            default: begin
                value = '0;
            end
        endcase
    end

endmodule

//--- logic/mem_access_unit.sv
`timescale 1ns/1ps

module mem_access_unit #(
    parameter int MEM_ADDR_W  = 5,
    parameter int RAM_LATENCY = 2
) (
    input  logic                   me_clk,
    input  logic                   me_rst,
    input  logic                   ce,
    input  logic                   flush,
    input  mem_stage_pkg::ex_mem_t ex,
    output logic                   busy,
    output logic                   mem_done,
    output mem_stage_pkg::mem_wb_t mem_rec
);
    import mem_stage_pkg::*;

    // room for every request the RAM can hold in flight
    localparam int SKIP_W = $clog2(RAM_LATENCY + 1);

    logic                  is_load;
    logic                  is_store;
    logic                  req;
    logic                  ack;
    logic                  ack_live;
    logic                  ack_stale;
    logic                  drop;
    logic [SKIP_W-1:0]     skip_cnt;
    logic [BE_W-1:0]       be;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W-1:0]     rdata;
    logic [DATA_W-1:0]     load_value;
    logic [OPCODE_W-1:0]   opcode_q;
    logic [FUNCT3_W-1:0]   funct3_q;
    logic [REG_ADDR_W-1:0] rd_addr_q;
    logic [1:0]            offset_q;
    logic                  load_q;

    assign is_load  = ex.opcode[OP_LOAD];
    assign is_store = ex.opcode[OP_STORE];

    // request strobes in the accept cycle itself
    assign req = ce && !flush && !busy && (is_load || is_store);

    // acks of flushed requests still drain out of the RAM in order
    assign ack_live  = ack && (skip_cnt == '0);
    assign ack_stale = ack && (skip_cnt != '0);
    assign drop      = busy && flush && !ack_live;

    always_ff @(posedge me_clk or negedge me_rst) begin
        if (!me_rst) begin
            busy     <= 1'b0;
            skip_cnt <= '0;
        end else begin
            if (req) begin
                busy <= 1'b1;
            end else if (ack_live || flush) begin
                busy <= 1'b0;
            end
            skip_cnt <= skip_cnt + SKIP_W'(drop) - SKIP_W'(ack_stale);
        end
    end

    // details of the pending access, needed again on ack
    always_ff @(posedge me_clk) begin
        if (req) begin
            opcode_q  <= ex.opcode;
            funct3_q  <= ex.funct3;
            rd_addr_q <= ex.rd_addr;
            offset_q  <= ex.alu_value[1:0];
            load_q    <= is_load;
        end
    end

    store_align u_store_align (
        .funct3   (ex.funct3),
        .offset   (ex.alu_value[1:0]),
        .rs2_data (ex.rs2_data),
        .wdata    (wdata),
        .be       (be)
    );

    data_ram #(
        .MEM_ADDR_W  (MEM_ADDR_W),
        .RAM_LATENCY (RAM_LATENCY)
    ) u_data_ram (
        .me_clk (me_clk),
        .me_rst (me_rst),
        .req    (req),
        .we     (is_store),
        .addr   (ex.alu_value[MEM_ADDR_W+1:2]),
        .be     (be),
        .wdata  (wdata),
        .ack    (ack),
        .rdata  (rdata)
    );

    load_extend u_load_extend (
        .funct3 (funct3_q),
        .offset (offset_q),
        .rdata  (rdata),
        .value  (load_value)
    );

    // a live ack only ever answers the pending request
    assign mem_done = ack_live;

    // stores retire with no register write
    always_comb begin
        mem_rec.opcode  = opcode_q;
        mem_rec.funct3  = funct3_q;
        mem_rec.rd_addr = rd_addr_q;
        mem_rec.rd_we   = load_q;
        mem_rec.rd_data = load_q ? load_value : '0;
    end

endmodule

//--- logic/reg_passthrough.sv
`timescale 1ns/1ps

module reg_passthrough (
    input  logic                   me_clk,
    input  logic                   me_rst,
    input  logic                   ce,
    input  logic                   flush,
    input  logic                   busy,
    input  mem_stage_pkg::ex_mem_t ex,
    output logic                   alu_done,
    output mem_stage_pkg::mem_wb_t alu_rec
);
    import mem_stage_pkg::*;

    logic is_mem;
    logic writes_reg;
    logic accept;

    assign is_mem = ex.opcode[OP_LOAD] || ex.opcode[OP_STORE];

    // classes that produce a register result
    assign writes_reg = ex.opcode[OP_RTYPE] || ex.opcode[OP_ITYPE] ||
                        ex.opcode[OP_JAL]   || ex.opcode[OP_JALR]  ||
                        ex.opcode[OP_LUI]   || ex.opcode[OP_AUIPC];

    // nothing is taken while a memory access is pending
    assign accept = ce && !flush && !busy && !is_mem;

    always_ff @(posedge me_clk or negedge me_rst) begin
        if (!me_rst) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= accept;
        end
    end

    always_ff @(posedge me_clk) begin
        if (accept) begin
            alu_rec.opcode  <= ex.opcode;
            alu_rec.funct3  <= ex.funct3;
            alu_rec.rd_addr <= ex.rd_addr;
            alu_rec.rd_we   <= ex.we_reg && writes_reg;
            alu_rec.rd_data <= ex.rd_data;
        end
    end

endmodule

//--- logic/writeback_merge.sv
`timescale 1ns/1ps

module writeback_merge (
    input  logic                   me_clk,
    input  logic                   me_rst,
    input  logic                   flush,
    input  logic                   busy,
    input  logic                   alu_done,
    input  mem_stage_pkg::mem_wb_t alu_rec,
    input  logic                   mem_done,
    input  mem_stage_pkg::mem_wb_t mem_rec,
    output mem_stage_pkg::mem_wb_t wb,
    output logic                   wb_ce,
    output logic                   stall,
    output logic                   flush_q
);
    import mem_stage_pkg::*;

    logic    commit;
    mem_wb_t sel_rec;

    // a flush in the done cycle squashes the result
    assign commit = (alu_done || mem_done) && !flush;

    // only one instruction in flight, so the done pulses never overlap
    assign sel_rec = mem_done ? mem_rec : alu_rec;

    always_ff @(posedge me_clk or negedge me_rst) begin
        if (!me_rst) begin
            wb      <= '0;
            wb_ce   <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            wb_ce   <= commit;
            flush_q <= flush;
            if (commit) begin
                wb <= sel_rec;
            end
        end
    end

    // upstream holds while the RAM access is open
    assign stall = busy;

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
    parameter int MEM_ADDR_W  = 5,
    parameter int RAM_LATENCY = 2
) (
    input  logic                   me_clk,
    input  logic                   me_rst,
    input  logic                   ce,
    input  logic                   flush,
    input  mem_stage_pkg::ex_mem_t ex,
    output mem_stage_pkg::mem_wb_t wb,
    output logic                   wb_ce,
    output logic                   stall,
    output logic                   flush_q
);
    import mem_stage_pkg::*;

    logic    busy;
    logic    mem_done;
    logic    alu_done;
    mem_wb_t mem_rec;
    mem_wb_t alu_rec;

    // loads and stores
    mem_access_unit #(
        .MEM_ADDR_W  (MEM_ADDR_W),
        .RAM_LATENCY (RAM_LATENCY)
    ) u_mem_access_unit (
        .me_clk   (me_clk),
        .me_rst   (me_rst),
        .ce       (ce),
        .flush    (flush),
        .ex       (ex),
        .busy     (busy),
        .mem_done (mem_done),
        .mem_rec  (mem_rec)
    );

    // every other class
    reg_passthrough u_reg_passthrough (
        .me_clk   (me_clk),
        .me_rst   (me_rst),
        .ce       (ce),
        .flush    (flush),
        .busy     (busy),
        .ex       (ex),
        .alu_done (alu_done),
        .alu_rec  (alu_rec)
    );

    writeback_merge u_writeback_merge (
        .me_clk   (me_clk),
        .me_rst   (me_rst),
        .flush    (flush),
        .busy     (busy),
        .alu_done (alu_done),
        .alu_rec  (alu_rec),
        .mem_done (mem_done),
        .mem_rec  (mem_rec),
        .wb       (wb),
        .wb_ce    (wb_ce),
        .stall    (stall),
        .flush_q  (flush_q)
    );

endmodule

//--- testbench/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// shadow copy of the data RAM, one entry per byte lane
logic [7:0] shadow [1 << MEM_ADDR_W][4];

function automatic void clear_shadow();
    for (int w = 0; w < (1 << MEM_ADDR_W); w++) begin
        for (int b = 0; b < 4; b++) begin
            shadow[w][b] = 8'h00;
        end
    end
endfunction

// word index taken from address bits 2 and up
function automatic int word_index(input logic [31:0] addr);
    return int'(addr[MEM_ADDR_W+1:2]);
endfunction

function automatic void apply_store(input logic [2:0] funct3, input logic [31:0] addr,
                                    input logic [31:0] data);
    int w;
    int off;
    w   = word_index(addr);
    off = int'(addr[1:0]);
    if (funct3 == F3_B) begin
        shadow[w][off] = data[7:0];
    end else if (funct3 == F3_H && off < 3) begin
        shadow[w][off]     = data[7:0];
        shadow[w][off + 1] = data[15:8];
    end else if (funct3 == F3_W) begin
        // whole word whatever the offset
        for (int b = 0; b < 4; b++) begin
            shadow[w][b] = data[8*b +: 8];
        end
    end
endfunction

function automatic logic [31:0] shadow_load(input logic [2:0] funct3, input logic [31:0] addr);
    logic [7:0] lane [4];
    int         w;
    int         off;
    w   = word_index(addr);
    off = int'(addr[1:0]);
    // bytes above the top lane read back as zero
    for (int i = 0; i < 4; i++) begin
        lane[i] = (off + i < 4) ? shadow[w][off + i] : 8'h00;
    end
    case (funct3)
        F3_B:    return {{24{lane[0][7]}}, lane[0]};
        F3_BU:   return {24'h0, lane[0]};
        F3_H:    return {{16{lane[1][7]}}, lane[1], lane[0]};
        F3_HU:   return {16'h0, lane[1], lane[0]};
        F3_W:    return {lane[3], lane[2], lane[1], lane[0]};
        default: return 32'h0;
    endcase
endfunction

// expected write-back record, stores also update the shadow
function automatic mem_wb_t expected_rec(input ex_mem_t e);
    mem_wb_t r;
    logic    writes;
    r.opcode  = e.opcode;
    r.funct3  = e.funct3;
    r.rd_addr = e.rd_addr;
    writes = e.opcode[OP_RTYPE] || e.opcode[OP_ITYPE] || e.opcode[OP_JAL] ||
             e.opcode[OP_JALR] || e.opcode[OP_LUI] || e.opcode[OP_AUIPC];
    if (e.opcode[OP_LOAD]) begin
        r.rd_we   = 1'b1;
        r.rd_data = shadow_load(e.funct3, e.alu_value);
    end else if (e.opcode[OP_STORE]) begin
        r.rd_we   = 1'b0;
        r.rd_data = 32'h0;
        apply_store(e.funct3, e.alu_value, e.rs2_data);
    end else begin
        r.rd_we   = e.we_reg && writes;
        r.rd_data = e.rd_data;
    end
    return r;
endfunction

`endif

//--- testbench/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;
    import mem_stage_pkg::*;

    // same values as the DUT defaults
    localparam int MEM_ADDR_W  = 5;
    localparam int RAM_LATENCY = 2;
    localparam int N_ALU       = 40;
    localparam int N_WORD      = 8;
    localparam int N_STALL     = 4;
    localparam int N_FLUSH     = 4;
    // narrow test runs 8 groups of 7 ops, flush test ends with 3 extra ops
    localparam int N_INSTR     = N_ALU + 2 * N_WORD + 56 + 2 * N_STALL + 2 * N_FLUSH + 3;
    localparam int TIMEOUT_CYC = N_INSTR * (RAM_LATENCY + 4) + 100;

    logic    me_clk;
    logic    me_rst;
    logic    ce;
    logic    flush;
    ex_mem_t ex;
    mem_wb_t wb;
    logic    wb_ce;
    logic    stall;
    logic    flush_q;

    integer  seed;
    int      cyc;
    logic    flush_d;
    int      err_cnt;
    int      check_cnt;
    int      test_base;
    int      tests_pass;
    int      tests_fail;
    mem_wb_t exp_q [$];
    int      issue_q [$];
    int      lat_q [$];

    `include "tb_ref.svh"

    mem_stage u_mem_stage (
        .me_clk  (me_clk),
        .me_rst  (me_rst),
        .ce      (ce),
        .flush   (flush),
        .ex      (ex),
        .wb      (wb),
        .wb_ce   (wb_ce),
        .stall   (stall),
        .flush_q (flush_q)
    );

    always #2 me_clk = ~me_clk;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("ERR %s: got %h expected %h", name, got, want);
            err_cnt++;
        end
    endtask

    task automatic check_result();
        mem_wb_t exp;
        int      lat;
        int      want_lat;
        if (exp_q.size() == 0) begin
            $display("write-back pulse at cycle %0d with no instruction outstanding", cyc);
            err_cnt++;
        end else begin
            exp      = exp_q.pop_front();
            // rise edge is one before this sampling edge
            lat      = cyc - 1 - issue_q.pop_front();
            want_lat = lat_q.pop_front();
            check_cnt++;
            compare_field("wb.opcode", 32'(wb.opcode), 32'(exp.opcode));
            compare_field("wb.funct3", 32'(wb.funct3), 32'(exp.funct3));
            compare_field("wb.rd_addr", 32'(wb.rd_addr), 32'(exp.rd_addr));
            compare_field("wb.rd_we", 32'(wb.rd_we), 32'(exp.rd_we));
            compare_field("wb.rd_data", wb.rd_data, exp.rd_data);
            if (lat != want_lat) begin
                $display("result arrived %0d cycles after issue, expected %0d", lat, want_lat);
                err_cnt++;
            end
        end
    endtask

    // outputs read before this edge's updates land
    always @(posedge me_clk) begin
        cyc     <= cyc + 1;
        flush_d <= flush;
        if (me_rst) begin
            if (flush_q !== flush_d) begin
                $display("ERR flush_q: got %h expected %h", flush_q, flush_d);
                err_cnt++;
            end
            if (wb_ce) begin
                check_result();
            end
        end
    end

    always @(posedge me_clk) begin
        if (cyc >= TIMEOUT_CYC) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic ex_mem_t random_alu_op();
        ex_mem_t e;
        int      cls;
        e           = '0;
        cls         = ($random(seed) & 32'h7fff_ffff) % 7;
        e.funct3    = FUNCT3_W'($random(seed));
        e.rd_addr   = REG_ADDR_W'($random(seed));
        e.we_reg    = 1'($random(seed));
        e.alu_value = $random(seed);
        e.rs2_data  = $random(seed);
        e.rd_data   = $random(seed);
        case (cls)
            0: e.opcode[OP_RTYPE] = 1'b1;
            1: e.opcode[OP_ITYPE] = 1'b1;
            2: e.opcode[OP_JAL]   = 1'b1;
            3: e.opcode[OP_JALR]  = 1'b1;
            4: e.opcode[OP_LUI]   = 1'b1;
            5: e.opcode[OP_AUIPC] = 1'b1;
            // empty opcode, no class writes
            default: e.opcode = '0;
        endcase
        return e;
    endfunction

    function automatic ex_mem_t mem_op(input int op_bit, input logic [2:0] funct3,
                                       input logic [31:0] addr, input logic [31:0] data);
        ex_mem_t e;
        e                = '0;
        e.opcode[op_bit] = 1'b1;
        e.funct3         = funct3;
        e.rd_addr        = REG_ADDR_W'($random(seed));
        e.we_reg         = 1'b1;
        e.alu_value      = addr;
        e.rs2_data       = data;
        e.rd_data        = $random(seed);
        return e;
    endfunction

    // called right at the edge that presents the op
    task automatic push_expected(input ex_mem_t e);
        exp_q.push_back(expected_rec(e));
        issue_q.push_back(cyc);
        lat_q.push_back((e.opcode[OP_LOAD] || e.opcode[OP_STORE]) ? RAM_LATENCY + 1 : 2);
    endtask

    task automatic wait_idle();
        @(negedge me_clk);
        while (stall) begin
            @(negedge me_clk);
        end
    endtask

    task automatic issue(input ex_mem_t e);
        @(posedge me_clk);
        ce <= 1'b1;
        ex <= e;
        push_expected(e);
        @(posedge me_clk);
        ce <= 1'b0;
        wait_idle();
    endtask

    task automatic offer_with_flush(input ex_mem_t e);
        @(posedge me_clk);
        ce    <= 1'b1;
        flush <= 1'b1;
        ex    <= e;
        @(posedge me_clk);
        ce    <= 1'b0;
        flush <= 1'b0;
        wait_idle();
    endtask

    task automatic end_test(input string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < RAM_LATENCY + 4) begin
            @(negedge me_clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected results never arrived", name, exp_q.size());
            err_cnt += exp_q.size();
            exp_q.delete();
            issue_q.delete();
            lat_q.delete();
        end
        // a stray pulse lands inside this test
        repeat (2) @(negedge me_clk);
        if (err_cnt == test_base) begin
            tests_pass++;
            $display("test %s: PASS", name);
        end else begin
            tests_fail++;
            $display("test %s: FAIL, %0d errors", name, err_cnt - test_base);
        end
        test_base = err_cnt;
    endtask

    task automatic run_narrow_test();
        logic [FUNCT3_W-1:0] load_codes [5];
        logic [31:0]         addr;
        load_codes = '{F3_B, F3_BU, F3_H, F3_HU, F3_W};
        for (int off = 0; off < 4; off++) begin
            for (int half = 0; half < 2; half++) begin
                addr      = $random(seed);
                addr[1:0] = off[1:0];
                // background word so untouched bytes are visible
                issue(mem_op(OP_STORE, F3_W, addr, $random(seed)));
                issue(mem_op(OP_STORE, (half != 0) ? F3_H : F3_B, addr, $random(seed)));
                for (int l = 0; l < 5; l++) begin
                    issue(mem_op(OP_LOAD, load_codes[l], addr, 32'h0));
                end
            end
        end
        end_test("narrow store and load");
    endtask

    task automatic run_stall_test();
        ex_mem_t ld;
        int      high;
        for (int n = 0; n < N_STALL; n++) begin
            ld = mem_op(OP_LOAD, F3_W, $random(seed), 32'h0);
            @(posedge me_clk);
            ce <= 1'b1;
            ex <= ld;
            push_expected(ld);
            @(posedge me_clk);
            // ce held up with another op across the stall
            ex   <= random_alu_op();
            high = 0;
            for (int i = 0; i < RAM_LATENCY; i++) begin
                @(negedge me_clk);
                if (stall) begin
                    high++;
                end
                @(posedge me_clk);
            end
            ce <= 1'b0;
            @(negedge me_clk);
            if (high != RAM_LATENCY || stall) begin
                $display("stall was high %0d cycles and %0d after ack, expected %0d and 0",
                         high, stall, RAM_LATENCY);
                err_cnt++;
            end
        end
        end_test("stall window");
    endtask

    task automatic run_flush_test();
        ex_mem_t     ld;
        logic [31:0] addr;
        for (int n = 0; n < N_FLUSH; n++) begin
            addr = $random(seed);
            ld   = mem_op(OP_LOAD, F3_W, addr, 32'h0);
            // this load gets flushed, nothing expected
            @(posedge me_clk);
            ce <= 1'b1;
            ex <= ld;
            @(posedge me_clk);
            ce <= 1'b0;
            repeat (n % RAM_LATENCY) @(posedge me_clk);
            flush <= 1'b1;
            @(posedge me_clk);
            flush <= 1'b0;
            wait_idle();
            issue(ld);
        end
        // dropped store must leave the word as it was
        addr      = $random(seed);
        addr[1:0] = 2'b00;
        offer_with_flush(mem_op(OP_STORE, F3_W, addr, ~shadow_load(F3_W, addr)));
        offer_with_flush(random_alu_op());
        issue(mem_op(OP_LOAD, F3_W, addr, 32'h0));
        end_test("flush");
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        me_clk     = 1'b0;
        me_rst     = 1'b0;
        ce         = 1'b0;
        flush      = 1'b0;
        ex         = '0;
        seed       = 41843;
        cyc        = 0;
        flush_d    = 1'b0;
        err_cnt    = 0;
        check_cnt  = 0;
        test_base  = 0;
        tests_pass = 0;
        tests_fail = 0;
        clear_shadow();
        repeat (4) @(posedge me_clk);
        me_rst <= 1'b1;
        @(negedge me_clk);
        if (wb_ce || stall || flush_q || wb.rd_we) begin
            $display("outputs not idle after reset");
            err_cnt++;
        end
        for (int i = 0; i < N_ALU; i++) begin
            issue(random_alu_op());
        end
        end_test("non-memory passthrough");
        for (int i = 0; i < N_WORD; i++) begin
            addr      = $random(seed);
            addr[1:0] = 2'b00;
            data      = $random(seed);
            issue(mem_op(OP_STORE, F3_W, addr, data));
            issue(mem_op(OP_LOAD, F3_W, addr, 32'h0));
        end
        end_test("word store and load");
        run_narrow_test();
        run_stall_test();
        run_flush_test();
        $display("summary: %0d tests passed, %0d failed, %0d results checked, %0d errors",
                 tests_pass, tests_fail, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+testbench
logic/mem_stage_pkg.sv
logic/store_align.sv
logic/data_ram.sv
logic/load_extend.sv
logic/mem_access_unit.sv
logic/reg_passthrough.sv
logic/writeback_merge.sv
logic/mem_stage.sv
testbench/tb_mem_stage.sv
